/* design/fpu_pkg.sv */
`default_nettype none

package fpu_pkg;

    typedef struct packed {
        logic        sign;
        logic [7:0]  exp;
        logic [22:0] frac;
    } fp32_t;

    typedef enum logic [3:0] {
        OP_NONE    = 4'd0,
        OP_LOAD    = 4'd1,
        OP_STORE   = 4'd2,
        OP_ADD     = 4'd3,
        OP_SUB     = 4'd4,
        OP_MUL     = 4'd5,
        OP_CVT_W_S = 4'd6,
        OP_CVT_S_W = 4'd7,
        OP_MV_X_W  = 4'd8,
        OP_MV_W_X  = 4'd9
    } fpu_op_e;

    typedef struct packed {
        fpu_op_e    op;
        logic [4:0] rd;
        logic       we;
    } fpu_uop_t;

    // Chain stages, counted in cycles after issue.
    localparam int FPU_WB_STAGE   = 5;
    localparam int FPU_LOAD_STAGE = 2;
    localparam int FPU_INT_STAGE  = 2;
    localparam int FPU_ADD_STAGE  = 3;
    localparam int FPU_MUL_STAGE  = 4;

    localparam int FPU_NUM_REGS = 32;
    localparam int FP_BIAS      = 127;

    localparam logic [7:0]  FP_EXP_MAX = 8'hff;
    localparam logic [31:0] INT32_MAX  = 32'h7fff_ffff;
    localparam logic [31:0] INT32_MIN  = 32'h8000_0000;

    localparam logic [6:0] OPC_LOAD_FP  = 7'b0000111;
    localparam logic [6:0] OPC_STORE_FP = 7'b0100111;
    localparam logic [6:0] OPC_OP_FP    = 7'b1010011;

    localparam logic [2:0] F3_WORD = 3'b010;
    localparam logic [2:0] F3_FMV  = 3'b000;
    localparam logic [1:0] FMT_S   = 2'b00;

    localparam logic [4:0] F5_FADD     = 5'b00000;
    localparam logic [4:0] F5_FSUB     = 5'b00001;
    localparam logic [4:0] F5_FMUL     = 5'b00010;
    localparam logic [4:0] F5_FCVT_W_S = 5'b11000;
    localparam logic [4:0] F5_FCVT_S_W = 5'b11010;
    localparam logic [4:0] F5_FMV_X_W  = 5'b11100;
    localparam logic [4:0] F5_FMV_W_X  = 5'b11110;

    // Leading zeros of a word, 32 when the word is zero.
    function automatic logic [5:0] lzc32(input logic [31:0] v);
        logic [5:0] n;
        logic       found;
        n = 6'd32;
        found = 1'b0;
        for (int i = 31; i >= 0; i--) begin
            if (v[i] && !found) begin
                n = 6'(31 - i);
                found = 1'b1;
            end
        end
        return n;
    endfunction

endpackage

`default_nettype wire

/* design/fpu_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module fpu_decoder (
    input  wire [31:0]         inst,
    input  wire                inst_valid,
    output fpu_pkg::fpu_uop_t  uop,
    output logic               illegal
);
    import fpu_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [4:0] funct5;
    logic [1:0] fmt;
    logic [4:0] rs2;
    fpu_op_e    op;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct5 = inst[31:27];
    assign fmt    = inst[26:25];
    assign rs2    = inst[24:20];

    // The rm field is ignored since only truncation is supported.
    always_comb begin
        op = OP_NONE;
        case (opcode)
            OPC_LOAD_FP: begin
                if (funct3 == F3_WORD)
                    op = OP_LOAD;
            end
            OPC_STORE_FP: begin
                if (funct3 == F3_WORD)
                    op = OP_STORE;
            end
            OPC_OP_FP: begin
                if (fmt == FMT_S) begin
                    case (funct5)
                        F5_FADD: op = OP_ADD;
                        F5_FSUB: op = OP_SUB;
                        F5_FMUL: op = OP_MUL;
                        F5_FCVT_W_S: begin
                            if (rs2 == 5'd0)
                                op = OP_CVT_W_S;
                        end
                        F5_FCVT_S_W: begin
                            if (rs2 == 5'd0)
                                op = OP_CVT_S_W;
                        end
                        F5_FMV_X_W: begin
                            if (rs2 == 5'd0 && funct3 == F3_FMV)
                                op = OP_MV_X_W;
                        end
                        F5_FMV_W_X: begin
                            if (rs2 == 5'd0 && funct3 == F3_FMV)
                                op = OP_MV_W_X;
                        end
                        default: op = OP_NONE;
                    endcase
                end
            end
            default: op = OP_NONE;
        endcase
    end

    // Stores and integer-bound results leave the float file alone.
    always_comb begin
        uop.op = inst_valid ? op : OP_NONE;
        uop.rd = inst[11:7];
        uop.we = inst_valid &&
                 (op inside {OP_LOAD, OP_ADD, OP_SUB, OP_MUL, OP_CVT_S_W, OP_MV_W_X});
    end

    assign illegal = inst_valid && (op == OP_NONE);

endmodule

`default_nettype wire

/* design/float_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module float_regfile (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire [4:0]            rs1,
    input  wire [4:0]            rs2,
    input  wire [4:0]            rd,
    input  wire fpu_pkg::fp32_t  wdata,
    input  wire                  we,
    output fpu_pkg::fp32_t       rdata1,
    output fpu_pkg::fp32_t       rdata2
);
    import fpu_pkg::*;

    fp32_t regs [FPU_NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < FPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[rd] <= wdata;
        end
    end

    // No bypass. A write shows on the read ports one cycle later.
    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

endmodule

`default_nettype wire

/* design/fp_addsub.sv */
`timescale 1ns/1ns
`default_nettype none

module fp_addsub (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire fpu_pkg::fp32_t  a,
    input  wire fpu_pkg::fp32_t  b,
    input  wire                  sub,
    output fpu_pkg::fp32_t       sum
);
    import fpu_pkg::*;

    fp32_t       af;
    fp32_t       bf;
    fp32_t       op_big;
    fp32_t       op_small;
    logic [7:0]  shift;
    logic        a_inf;
    logic        b_inf;

    logic        s1_sign;
    logic [7:0]  s1_exp;
    logic [23:0] s1_big;
    logic [23:0] s1_small;
    logic        s1_eff_sub;
    logic        s1_inf;
    logic        s1_inf_sign;

    logic [24:0]       mag;
    logic [5:0]        lz;
    logic [23:0]       norm;
    logic signed [9:0] exp_n;
    fp32_t             res;

    // Stage 1. Order by magnitude and align.
    always_comb begin
        af = a;
        bf = b;
        bf.sign = b.sign ^ sub;
        if (a.exp == '0)
            af.frac = '0;
        if (b.exp == '0)
            bf.frac = '0;
        a_inf = (a.exp == FP_EXP_MAX);
        b_inf = (b.exp == FP_EXP_MAX);
        if (af[30:0] >= bf[30:0]) begin
            op_big = af;
            op_small = bf;
        end else begin
            op_big = bf;
            op_small = af;
        end
        shift = op_big.exp - op_small.exp;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_eff_sub <= 1'b0;
            s1_inf <= 1'b0;
        end else begin
            s1_eff_sub <= op_big.sign ^ op_small.sign;
            s1_inf <= a_inf || b_inf;
        end
    end

    // Bits shifted past the LSB are simply lost.
    always_ff @(posedge clk) begin
        s1_sign <= op_big.sign;
        s1_exp <= op_big.exp;
        s1_big <= {op_big.exp != '0, op_big.frac};
        s1_small <= {op_small.exp != '0, op_small.frac} >> shift;
        s1_inf_sign <= a_inf ? af.sign : bf.sign;
    end

    // Stage 2. Add, normalize, apply range rules.
    always_comb begin
        if (s1_eff_sub)
            mag = {1'b0, s1_big} - {1'b0, s1_small};
        else
            mag = {1'b0, s1_big} + {1'b0, s1_small};
        lz = lzc32({mag[23:0], 8'h00});
        if (mag[24]) begin
            norm = mag[24:1];
            exp_n = 10'(s1_exp) + 10'sd1;
        end else begin
            norm = mag[23:0] << lz;
            exp_n = 10'(s1_exp) - 10'(lz);
        end
        res = {s1_sign, exp_n[7:0], norm[22:0]};
        if (s1_inf)
            res = {s1_inf_sign, FP_EXP_MAX, 23'd0};
        else if (mag == '0)
            res = '0;
        else if (exp_n >= 10'sd255)
            res = {s1_sign, FP_EXP_MAX, 23'd0};
        else if (exp_n <= 10'sd0)
            res = {s1_sign, 31'd0};
    end

    always_ff @(posedge clk) begin
        sum <= res;
    end

endmodule

`default_nettype wire

/* design/fp_mult.sv */
`timescale 1ns/1ns
`default_nettype none

module fp_mult (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire fpu_pkg::fp32_t  a,
    input  wire fpu_pkg::fp32_t  b,
    output fpu_pkg::fp32_t       prod
);
    import fpu_pkg::*;

    logic              s1_sign;
    logic signed [9:0] s1_exp;
    logic [23:0]       s1_sa;
    logic [23:0]       s1_sb;
    logic              s1_zero;
    logic              s1_inf;

    logic              s2_sign;
    logic signed [9:0] s2_exp;
    logic [47:0]       s2_prod;
    logic              s2_zero;
    logic              s2_inf;

    logic [22:0]       mant;
    logic signed [9:0] exp_n;
    fp32_t             res;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_zero <= 1'b0;
            s1_inf <= 1'b0;
            s2_zero <= 1'b0;
            s2_inf <= 1'b0;
        end else begin
            s1_zero <= (a.exp == '0) || (b.exp == '0);
            s1_inf <= (a.exp == FP_EXP_MAX) || (b.exp == FP_EXP_MAX);
            s2_zero <= s1_zero;
            s2_inf <= s1_inf;
        end
    end

    always_ff @(posedge clk) begin
        s1_sign <= a.sign ^ b.sign;
        s1_exp <= 10'(a.exp) + 10'(b.exp) - 10'(FP_BIAS);
        s1_sa <= {1'b1, a.frac};
        s1_sb <= {1'b1, b.frac};
        s2_sign <= s1_sign;
        s2_exp <= s1_exp;
        s2_prod <= s1_sa * s1_sb;
    end

    // Product lies in [1,4), so one shift at most.
    always_comb begin
        if (s2_prod[47]) begin
            mant = s2_prod[46:24];
            exp_n = s2_exp + 10'sd1;
        end else begin
            mant = s2_prod[45:23];
            exp_n = s2_exp;
        end
        res = {s2_sign, exp_n[7:0], mant};
        if (s2_inf)
            res = {s2_sign, FP_EXP_MAX, 23'd0};
        else if (s2_zero || exp_n <= 10'sd0)
            res = {s2_sign, 31'd0};
        else if (exp_n >= 10'sd255)
            res = {s2_sign, FP_EXP_MAX, 23'd0};
    end

    always_ff @(posedge clk) begin
        prod <= res;
    end

endmodule

`default_nettype wire

/* design/fp_convert.sv */
`timescale 1ns/1ns
`default_nettype none

module fp_convert (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire fpu_pkg::fp32_t  fval,
    input  wire [31:0]           ival,
    output logic [31:0]          to_int,
    output fpu_pkg::fp32_t       to_float
);
    import fpu_pkg::*;

    logic signed [9:0] k;
    logic [31:0]       sig;
    logic [31:0]       mag_f;
    logic [31:0]       int_res;
    logic              neg;
    logic [31:0]       mag_i;
    logic [5:0]        lz;
    logic [31:0]       norm;
    fp32_t             flt_res;

    // Float to integer, truncated toward zero.
    always_comb begin
        k = 10'(fval.exp) - 10'(FP_BIAS);
        sig = {8'd0, 1'b1, fval.frac};
        if (k >= 10'sd23)
            mag_f = sig << 5'(k - 10'sd23);
        else
            mag_f = sig >> 5'(10'sd23 - k);
        if (fval.exp == FP_EXP_MAX || k >= 10'sd31)
            int_res = fval.sign ? INT32_MIN : INT32_MAX;
        else if (fval.exp == '0 || k < 10'sd0)
            int_res = '0;
        else
            int_res = fval.sign ? -mag_f : mag_f;
    end

    // Integer to float. Low bits past 24 are dropped.
    always_comb begin
        neg = ival[31];
        mag_i = neg ? -ival : ival;
        lz = lzc32(mag_i);
        norm = mag_i << lz;
        flt_res.sign = neg;
        flt_res.exp = 8'(FP_BIAS + 31) - 8'(lz);
        flt_res.frac = norm[30:8];
        if (ival == '0)
            flt_res = '0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            to_int <= '0;
            to_float <= '0;
        end else begin
            to_int <= int_res;
            to_float <= flt_res;
        end
    end

endmodule

`default_nettype wire

/* design/fpu_pipeline.sv */
`timescale 1ns/1ns
`default_nettype none

module fpu_pipeline (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  inst_valid,
    input  wire [31:0]           inst,
    input  wire [31:0]           from_intreg,
    input  wire fpu_pkg::fp32_t  from_mem,
    output fpu_pkg::fp32_t       to_mem,
    output logic                 store_valid,
    output logic [31:0]          to_intreg,
    output logic                 int_valid,
    output logic                 illegal
);
    import fpu_pkg::*;

    fpu_uop_t    dec_uop;
    logic        dec_illegal;
    fp32_t       rdata1;
    fp32_t       rdata2;
    fp32_t       op_a;
    fp32_t       op_b;
    logic [31:0] fmv_bits;

    fpu_uop_t    uop_q [1:FPU_WB_STAGE];
    fp32_t       res_q [1:FPU_WB_STAGE];
    fp32_t       chain_in [1:FPU_WB_STAGE-1];

    fp32_t       addsub_out;
    fp32_t       mult_out;
    fp32_t       cvt_float;
    logic [31:0] cvt_int;

    fpu_decoder i_decoder (
        .inst       (inst),
        .inst_valid (inst_valid),
        .uop        (dec_uop),
        .illegal    (dec_illegal)
    );

    float_regfile i_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .rs1    (inst[19:15]),
        .rs2    (inst[24:20]),
        .rd     (uop_q[FPU_WB_STAGE].rd),
        .wdata  (res_q[FPU_WB_STAGE]),
        .we     (uop_q[FPU_WB_STAGE].we),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    fp_addsub i_addsub (
        .clk   (clk),
        .rst_n (rst_n),
        .a     (op_a),
        .b     (op_b),
        .sub   (uop_q[1].op == OP_SUB),
        .sum   (addsub_out)
    );

    fp_mult i_mult (
        .clk   (clk),
        .rst_n (rst_n),
        .a     (op_a),
        .b     (op_b),
        .prod  (mult_out)
    );

    // Stage 1 of the chain doubles as the integer operand.
    fp_convert i_convert (
        .clk      (clk),
        .rst_n    (rst_n),
        .fval     (op_a),
        .ival     (res_q[1]),
        .to_int   (cvt_int),
        .to_float (cvt_float)
    );

    always_comb begin
        for (int s = 1; s < FPU_WB_STAGE; s++) begin
            chain_in[s] = res_q[s];
        end
        if (uop_q[FPU_LOAD_STAGE].op == OP_LOAD)
            chain_in[FPU_LOAD_STAGE] = from_mem;
        if (uop_q[FPU_INT_STAGE].op == OP_CVT_S_W)
            chain_in[FPU_INT_STAGE] = cvt_float;
        if (uop_q[FPU_ADD_STAGE].op inside {OP_ADD, OP_SUB})
            chain_in[FPU_ADD_STAGE] = addsub_out;
        if (uop_q[FPU_MUL_STAGE].op == OP_MUL)
            chain_in[FPU_MUL_STAGE] = mult_out;
    end

    // Raw integer enters at stage 1, which is where FMV.W.X lands.
    always_ff @(posedge clk) begin
        op_a <= rdata1;
        op_b <= rdata2;
        fmv_bits <= op_a;
        res_q[1] <= from_intreg;
        for (int s = 2; s <= FPU_WB_STAGE; s++) begin
            res_q[s] <= chain_in[s-1];
        end
        if (dec_uop.op == OP_STORE)
            to_mem <= rdata2;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 1; s <= FPU_WB_STAGE; s++) begin
                uop_q[s] <= '0;
            end
            store_valid <= 1'b0;
            illegal <= 1'b0;
        end else begin
            uop_q[1] <= dec_uop;
            for (int s = 2; s <= FPU_WB_STAGE; s++) begin
                uop_q[s] <= uop_q[s-1];
            end
            store_valid <= (dec_uop.op == OP_STORE);
            illegal <= dec_illegal;
        end
    end

    assign int_valid = uop_q[FPU_INT_STAGE].op inside {OP_CVT_W_S, OP_MV_X_W};
    assign to_intreg = (uop_q[FPU_INT_STAGE].op == OP_MV_X_W) ? fmv_bits : cvt_int;

endmodule

`default_nettype wire

/* verification/fpu_model.svh */
`ifndef FPU_MODEL_SVH
`define FPU_MODEL_SVH

import fpu_pkg::*;

// Index of the highest set bit, -1 for zero.
function automatic int msb_index(input logic [63:0] v);
    int p;
    p = -1;
    for (int i = 0; i < 64; i++) begin
        if (v[i])
            p = i;
    end
    return p;
endfunction

// Packs a magnitude whose leading one sits at bit p, truncating the rest.
function automatic fp32_t pack_float(input logic sign, input int e,
                                     input logic [63:0] m, input int p);
    logic [63:0] aligned;
    fp32_t       f;
    if (p >= 23)
        aligned = m >> (p - 23);
    else
        aligned = m << (23 - p);
    if (e >= 255)
        f = {sign, 8'hff, 23'd0};
    else if (e <= 0)
        f = {sign, 31'd0};
    else
        f = {sign, 8'(e), aligned[22:0]};
    return f;
endfunction

function automatic fp32_t model_add(input fp32_t a, input fp32_t b, input logic sub);
    logic        sign_b;
    logic [63:0] ma;
    logic [63:0] mb;
    logic [63:0] mag;
    logic        a_big;
    int          shift;
    int          e_big;
    int          p;
    sign_b = b.sign ^ sub;
    if (a.exp == 8'hff)
        return {a.sign, 8'hff, 23'd0};
    if (b.exp == 8'hff)
        return {sign_b, 8'hff, 23'd0};
    ma = (a.exp == 8'd0) ? 64'd0 : {40'd0, 1'b1, a.frac};
    mb = (b.exp == 8'd0) ? 64'd0 : {40'd0, 1'b1, b.frac};
    a_big = (a.exp > b.exp) || (a.exp == b.exp && ma >= mb);
    e_big = a_big ? int'(a.exp) : int'(b.exp);
    shift = a_big ? int'(a.exp) - int'(b.exp) : int'(b.exp) - int'(a.exp);
    // Smaller operand loses whatever falls off the bottom.
    if (a_big)
        mb = mb >> shift;
    else
        ma = ma >> shift;
    if (a.sign == sign_b)
        mag = ma + mb;
    else
        mag = a_big ? ma - mb : mb - ma;
    if (mag == 64'd0)
        return '0;
    p = msb_index(mag);
    return pack_float(a_big ? a.sign : sign_b, e_big + p - 23, mag, p);
endfunction

function automatic fp32_t model_mul(input fp32_t a, input fp32_t b);
    logic        sign;
    logic [63:0] m;
    int          p;
    sign = a.sign ^ b.sign;
    if (a.exp == 8'hff || b.exp == 8'hff)
        return {sign, 8'hff, 23'd0};
    if (a.exp == 8'd0 || b.exp == 8'd0)
        return {sign, 31'd0};
    m = {40'd0, 1'b1, a.frac} * {40'd0, 1'b1, b.frac};
    p = msb_index(m);
    return pack_float(sign, int'(a.exp) + int'(b.exp) - FP_BIAS + p - 46, m, p);
endfunction

// Truncates toward zero, saturating out of range.
function automatic logic [31:0] model_f2i(input fp32_t a);
    int          e;
    logic [63:0] m;
    e = int'(a.exp) - FP_BIAS;
    if (a.exp == 8'hff || e >= 31)
        return a.sign ? 32'h8000_0000 : 32'h7fff_ffff;
    if (e < 0)
        return 32'd0;
    m = {40'd0, 1'b1, a.frac};
    if (e >= 23)
        m = m << (e - 23);
    else
        m = m >> (23 - e);
    return a.sign ? -m[31:0] : m[31:0];
endfunction

function automatic fp32_t model_i2f(input logic [31:0] v);
    logic [63:0] m;
    int          p;
    if (v == 32'd0)
        return '0;
    m = v[31] ? {32'd0, -v} : {32'd0, v};
    p = msb_index(m);
    return pack_float(v[31], FP_BIAS + p, m, p);
endfunction

`endif

/* verification/fpu_pipeline_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module fpu_pipeline_tb;
    `include "fpu_model.svh"

    localparam int NUM_INSTS  = 2000;
    localparam int MAX_CYCLES = 2 * NUM_INSTS + 100;
    localparam int HIST       = MAX_CYCLES + 64;

    typedef struct packed {
        logic [31:0] wr_cycle;
        logic        from_load;
        logic [4:0]  rd;
        fp32_t       value;
    } pend_t;

    logic        clk;
    logic        rst_n;
    logic        inst_valid;
    logic [31:0] inst;
    logic [31:0] from_intreg;
    fp32_t       from_mem;
    fp32_t       to_mem;
    logic        store_valid;
    logic [31:0] to_intreg;
    logic        int_valid;
    logic        illegal;

    integer      seed;
    int          cyc;
    int          cycles_run;
    int          errors;
    int          checks;
    int          issued;

    fp32_t       model_regs [FPU_NUM_REGS];
    fp32_t       mem_hist [HIST];
    logic        exp_store [HIST];
    fp32_t       exp_to_mem [HIST];
    logic        exp_int [HIST];
    logic [31:0] exp_to_int [HIST];
    logic        exp_illegal [HIST];
    pend_t       pending [$];

    fpu_pipeline i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .from_intreg (from_intreg),
        .from_mem    (from_mem),
        .to_mem      (to_mem),
        .store_valid (store_valid),
        .to_intreg   (to_intreg),
        .int_valid   (int_valid),
        .illegal     (illegal)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles_run++;
        if (cycles_run >= MAX_CYCLES) begin
            $display("Timeout: the run did not end within %0d cycles", MAX_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h, expected %h", $time, name, got, expected);
        end
    endtask

    // Mostly a small pool, so hazards and cancellations are common.
    function automatic logic [4:0] rand_reg();
        logic [31:0] r;
        r = $random(seed);
        return (r[4:3] == 2'b00) ? r[9:5] : {2'b00, r[2:0]};
    endfunction

    function automatic fp32_t rand_float();
        logic [31:0] r;
        logic [31:0] e;
        fp32_t       f;
        r = $random(seed);
        e = $random(seed);
        f = r;
        if (e[8])
            f.exp = 8'd100 + 8'(e[7:0] % 8'd60);
        else
            f.exp = 8'd1 + 8'(e[7:0] % 8'd254);
        return f;
    endfunction

    task automatic random_inst(output fpu_op_e op, output logic [31:0] word,
                               output logic [31:0] ival);
        logic [31:0] r;
        logic [31:0] imm;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        r = $random(seed);
        imm = $random(seed);
        rd = rand_reg();
        rs1 = rand_reg();
        rs2 = rand_reg();
        ival = $random(seed);
        if (r[3:0] == 4'd0) begin
            op = OP_NONE;
            case (r[5:4])
                2'd0: word = {imm[31:2], 2'b00};
                2'd1: word = {imm[31:27], 2'b01, imm[24:7], OPC_OP_FP};
                2'd2: word = {imm[31:15], 3'b011, imm[11:7], OPC_LOAD_FP};
                default: word = {5'b00011, FMT_S, imm[24:7], OPC_OP_FP};
            endcase
        end else begin
            case (r[7:4])
                4'd0, 4'd1, 4'd2: op = OP_LOAD;
                4'd3, 4'd4, 4'd14: op = OP_STORE;
                4'd5, 4'd6: op = OP_ADD;
                4'd7, 4'd15: op = OP_SUB;
                4'd8, 4'd9: op = OP_MUL;
                4'd10: op = OP_CVT_W_S;
                4'd11: op = OP_CVT_S_W;
                4'd12: op = OP_MV_X_W;
                default: op = OP_MV_W_X;
            endcase
            case (op)
                OP_LOAD: word = {imm[31:20], rs1, F3_WORD, rd, OPC_LOAD_FP};
                OP_STORE: word = {imm[31:25], rs2, rs1, F3_WORD, imm[11:7], OPC_STORE_FP};
                OP_ADD: word = {F5_FADD, FMT_S, rs2, rs1, imm[14:12], rd, OPC_OP_FP};
                OP_SUB: word = {F5_FSUB, FMT_S, rs2, rs1, imm[14:12], rd, OPC_OP_FP};
                OP_MUL: word = {F5_FMUL, FMT_S, rs2, rs1, imm[14:12], rd, OPC_OP_FP};
                OP_CVT_W_S: word = {F5_FCVT_W_S, FMT_S, 5'd0, rs1, imm[14:12], rd, OPC_OP_FP};
                OP_CVT_S_W: begin
                    word = {F5_FCVT_S_W, FMT_S, 5'd0, rs1, imm[14:12], rd, OPC_OP_FP};
                    ival = $signed(ival) >>> imm[4:0];
                end
                OP_MV_X_W: word = {F5_FMV_X_W, FMT_S, 5'd0, rs1, F3_FMV, rd, OPC_OP_FP};
                default: begin
                    word = {F5_FMV_W_X, FMT_S, 5'd0, rs1, F3_FMV, rd, OPC_OP_FP};
                    ival = rand_float();
                end
            endcase
        end
    endtask

    // Drives one instruction and books its expected effects.
    task automatic issue_inst(input fpu_op_e op, input logic [31:0] word,
                              input logic [31:0] ival);
        fp32_t a;
        fp32_t b;
        pend_t p;
        a = model_regs[word[19:15]];
        b = model_regs[word[24:20]];
        inst = word;
        inst_valid = 1'b1;
        from_intreg = ival;
        p.wr_cycle = cyc + FPU_WB_STAGE;
        p.from_load = (op == OP_LOAD);
        p.rd = word[11:7];
        p.value = '0;
        case (op)
            OP_STORE: begin
                exp_store[cyc + 1] = 1'b1;
                exp_to_mem[cyc + 1] = b;
            end
            OP_ADD: p.value = model_add(a, b, 1'b0);
            OP_SUB: p.value = model_add(a, b, 1'b1);
            OP_MUL: p.value = model_mul(a, b);
            OP_CVT_S_W: p.value = model_i2f(ival);
            OP_MV_W_X: p.value = ival;
            OP_CVT_W_S: begin
                exp_int[cyc + FPU_INT_STAGE] = 1'b1;
                exp_to_int[cyc + FPU_INT_STAGE] = model_f2i(a);
            end
            OP_MV_X_W: begin
                exp_int[cyc + FPU_INT_STAGE] = 1'b1;
                exp_to_int[cyc + FPU_INT_STAGE] = a;
            end
            OP_NONE: exp_illegal[cyc + 1] = 1'b1;
            default: ;
        endcase
        if (op inside {OP_LOAD, OP_ADD, OP_SUB, OP_MUL, OP_CVT_S_W, OP_MV_W_X})
            pending.push_back(p);
        issued++;
    endtask

    // One clock. Retire due writes, compare outputs, new memory word.
    task automatic next_cycle();
        pend_t p;
        @(posedge clk);
        #1;
        cyc++;
        while (pending.size() > 0 && pending[0].wr_cycle < cyc) begin
            p = pending.pop_front();
            if (p.from_load)
                p.value = mem_hist[p.wr_cycle - FPU_WB_STAGE + FPU_LOAD_STAGE];
            model_regs[p.rd] = p.value;
        end
        check_value("store_valid", 32'(store_valid), 32'(exp_store[cyc]));
        check_value("int_valid", 32'(int_valid), 32'(exp_int[cyc]));
        check_value("illegal", 32'(illegal), 32'(exp_illegal[cyc]));
        if (exp_store[cyc])
            check_value("to_mem", to_mem, exp_to_mem[cyc]);
        if (exp_int[cyc])
            check_value("to_intreg", to_intreg, exp_to_int[cyc]);
        inst_valid = 1'b0;
        from_mem = rand_float();
        mem_hist[cyc] = from_mem;
    endtask

    initial begin
        logic [31:0] r;
        fpu_op_e     op;
        logic [31:0] word;
        logic [31:0] ival;
        seed = 32'h8f5a;
        clk = 1'b0;
        rst_n = 1'b0;
        inst_valid = 1'b0;
        inst = '0;
        from_intreg = '0;
        from_mem = '0;
        cyc = 0;
        cycles_run = 0;
        errors = 0;
        checks = 0;
        issued = 0;
        for (int i = 0; i < FPU_NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < HIST; i++) begin
            mem_hist[i] = '0;
            exp_store[i] = 1'b0;
            exp_to_mem[i] = '0;
            exp_int[i] = 1'b0;
            exp_to_int[i] = '0;
            exp_illegal[i] = 1'b0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // Quiet cycles, outputs must stay idle.
        repeat (4) next_cycle();
        while (issued < NUM_INSTS) begin
            next_cycle();
            r = $random(seed);
            if (r[1:0] != 2'b00) begin
                random_inst(op, word, ival);
                issue_inst(op, word, ival);
            end
        end
        // Drain, then store every register once.
        repeat (FPU_WB_STAGE + 1) next_cycle();
        for (int i = 0; i < FPU_NUM_REGS; i++) begin
            next_cycle();
            issue_inst(OP_STORE, {7'd0, 5'(i), 5'd0, F3_WORD, 5'd0, OPC_STORE_FP}, 32'd0);
        end
        repeat (4) next_cycle();
        $display("Instructions: %0d, checks: %0d, errors: %0d", issued, checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* fpu_pipeline.f */
+incdir+verification
design/fpu_pkg.sv
design/fpu_decoder.sv
design/float_regfile.sv
design/fp_addsub.sv
design/fp_mult.sv
design/fp_convert.sv
design/fpu_pipeline.sv
verification/fpu_pipeline_tb.sv

/* Bender.yml */
package:
  name: fpu_pipeline

sources:
  - design/fpu_pkg.sv
  - design/fpu_decoder.sv
  - design/float_regfile.sv
  - design/fp_addsub.sv
  - design/fp_mult.sv
  - design/fp_convert.sv
  - design/fpu_pipeline.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/fpu_pipeline_tb.sv
